//--- verilog/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath and memory sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FETCH_XLEN 32             // pc and instruction width
`define FETCH_MEM_WORDS 256       // Instruction RAM depth
`define FETCH_MAX_LATENCY 7       // Upper clamp for response latency

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FETCH_WB_ADDR_W 12        // Byte address width
`define FETCH_MEM_WINDOW 12'h400  // Start of instruction memory window

`endif

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef enum logic [1:0] {
        idle,
        wait_ready,        // Want to issue a request
        wait_valid,        // Request outstanding
        hold               // Word parked while decode stalls
    } fetch_state_e;

    typedef enum logic {
        mem_idle,
        mem_busy
    } mem_state_e;

    // Index is byte offset / 4
    typedef enum logic [1:0] {
        reg_ctrl         = 2'd0,
        reg_reset_vector = 2'd1,
        reg_latency      = 2'd2,
        reg_fetch_count  = 2'd3
    } ctrl_reg_e;

    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011
    } opcode_e;

    // addi x0, x0, 0
    parameter logic [31:0] INST_NOP = {12'd0, 5'd0, 3'b000, 5'd0, op_imm};

endpackage

`default_nettype wire

//--- verilog/imem_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

interface imem_if;

    logic                   start;
    logic                   ready;
    logic [`FETCH_XLEN-1:0] addr;
    logic [`FETCH_XLEN-1:0] data;
    logic                   data_valid;

    modport fetch (
        output start,
        output addr,
        input  ready,
        input  data,
        input  data_valid
    );

    modport memory (
        input  start,
        input  addr,
        output ready,
        output data,
        output data_valid
    );

endinterface

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic [`FETCH_XLEN-1:0] reset_vector,
    input  logic                   redirect,
    input  logic [`FETCH_XLEN-1:0] redirect_pc,
    input  logic                   stall,
    imem_if.fetch                  mem,
    output logic                   id_valid,
    output logic [`FETCH_XLEN-1:0] id_pc,
    output logic [`FETCH_XLEN-1:0] id_inst,
    output logic                   delivered
);

    fetch_pkg::fetch_state_e state;

    logic [`FETCH_XLEN-1:0] pc;          // Address of the word in flight or held
    logic [`FETCH_XLEN-1:0] inst_q;
    logic [`FETCH_XLEN-1:0] hold_inst;
    logic                   discard;     // Outstanding response is stale
    logic                   resp_ok;
    logic                   issue_next;
    logic [`FETCH_XLEN-1:0] rv_aligned;
    logic [`FETCH_XLEN-1:0] rd_aligned;

    assign rv_aligned = {reset_vector[`FETCH_XLEN-1:2], 2'b00};
    assign rd_aligned = {redirect_pc[`FETCH_XLEN-1:2], 2'b00};

    assign resp_ok    = (state == fetch_pkg::wait_valid) && mem.data_valid
                        && !discard && !redirect;
    assign issue_next = resp_ok && !stall && enable;   // Back-to-back with delivery

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mem.start = 1'b0;
        mem.addr  = pc;
        if (!redirect && mem.ready) begin
            if (state == fetch_pkg::wait_ready && enable) begin
                mem.start = 1'b1;
            end else if (issue_next) begin
                mem.start = 1'b1;
                mem.addr  = pc + `FETCH_XLEN'(4);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_pkg::idle;
            pc       <= '0;
            discard  <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            if (!stall || redirect) begin
                id_valid <= 1'b0;          // Taken by decode or flushed
            end
            case (state)
                fetch_pkg::idle: begin
                    if (enable) begin
                        pc    <= rv_aligned;
                        state <= fetch_pkg::wait_ready;
                    end
                end
                fetch_pkg::wait_ready: begin
                    if (redirect) begin
                        pc <= rd_aligned;
                    end else if (!enable) begin
                        state <= fetch_pkg::idle;
                    end else if (mem.ready) begin
                        state <= fetch_pkg::wait_valid;
                    end
                end
                fetch_pkg::wait_valid: begin
                    if (redirect) begin
                        pc      <= rd_aligned;
                        discard <= !mem.data_valid;
                        if (mem.data_valid) begin
                            state <= fetch_pkg::wait_ready;
                        end
                    end else if (mem.data_valid) begin
                        if (discard) begin
                            discard <= 1'b0;
                            state   <= fetch_pkg::wait_ready;
                        end else if (stall) begin
                            state <= fetch_pkg::hold;
                        end else begin
                            id_valid <= 1'b1;
                            pc       <= pc + `FETCH_XLEN'(4);
                            state    <= enable ? fetch_pkg::wait_valid : fetch_pkg::idle;
                        end
                    end
                end
                fetch_pkg::hold: begin
                    if (redirect) begin
                        pc    <= rd_aligned;
                        state <= fetch_pkg::wait_ready;
                    end else if (!stall) begin
                        id_valid <= 1'b1;
                        pc       <= pc + `FETCH_XLEN'(4);
                        state    <= fetch_pkg::wait_ready;
                    end
                end
                default: state <= fetch_pkg::idle;
            endcase
        end
    end

    // Output and holding registers
    always_ff @(posedge clk) begin
        if (resp_ok && !stall) begin
            id_pc  <= pc;
            inst_q <= mem.data;
        end else if (state == fetch_pkg::hold && !redirect && !stall) begin
            id_pc  <= pc;
            inst_q <= hold_inst;
        end
        if (resp_ok && stall) begin
            hold_inst <= mem.data;
        end
    end

    assign id_inst   = id_valid ? inst_q : fetch_pkg::INST_NOP;
    assign delivered = id_valid && !stall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        id_valid && stall && !redirect |=> id_valid && $stable(id_pc) && $stable(id_inst));

    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        id_valid |-> id_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module inst_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [2:0]             latency,
    input  logic                   wr_en,
    input  logic [7:0]             wr_addr,
    input  logic [`FETCH_XLEN-1:0] wr_data,
    imem_if.memory                 mem
);

    localparam int AW = $clog2(`FETCH_MEM_WORDS);

    logic [`FETCH_XLEN-1:0] ram [0:`FETCH_MEM_WORDS-1];

    fetch_pkg::mem_state_e state;

    logic [AW-1:0]          rd_addr;
    logic [AW-1:0]          rd_sel;
    logic [`FETCH_XLEN-1:0] rd_data;
    logic [2:0]             count;
    logic [2:0]             lat_eff;
    logic                   accept;

    always_comb begin
        lat_eff = latency;
        if (latency == 3'd0) begin
            lat_eff = 3'd1;
        end else if (int'(latency) > `FETCH_MAX_LATENCY) begin
            lat_eff = 3'(`FETCH_MAX_LATENCY);
        end
    end

    assign mem.data_valid = (state == fetch_pkg::mem_busy) && (count == 3'd0);
    assign mem.ready      = (state == fetch_pkg::mem_idle) || mem.data_valid;
    assign mem.data       = rd_data;
    assign accept         = mem.start && mem.ready;
    assign rd_sel         = accept ? mem.addr[AW+1:2] : rd_addr;

    // Host write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_data;
        end
    end

    // Synchronous read, first copy lands the cycle after accept
    always_ff @(posedge clk) begin
        rd_data <= ram[rd_sel];
        if (accept) begin
            rd_addr <= mem.addr[AW+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_pkg::mem_idle;
            count <= '0;
        end else if (accept) begin
            state <= fetch_pkg::mem_busy;
            count <= lat_eff - 3'd1;
        end else if (state == fetch_pkg::mem_busy) begin
            if (count == 3'd0) begin
                state <= fetch_pkg::mem_idle;  // Response shown this cycle
            end else begin
                count <= count - 3'd1;
            end
        end
    end

    valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
        mem.data_valid |=> !mem.data_valid || $past(accept));

endmodule

`default_nettype wire

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`FETCH_WB_ADDR_W-1:0] wb_adr,
    input  logic [`FETCH_XLEN-1:0]      wb_dat_w,
    input  logic [3:0]                  wb_sel,
    output logic [`FETCH_XLEN-1:0]      wb_dat_r,
    output logic                        wb_ack,
    input  logic                        delivered,
    output logic                        enable,
    output logic [`FETCH_XLEN-1:0]      reset_vector,
    output logic [2:0]                  latency,
    output logic                        mem_wr_en,
    output logic [7:0]                  mem_wr_addr,
    output logic [`FETCH_XLEN-1:0]      mem_wr_data
);

    logic                        access;
    logic                        wr_access;
    logic                        reg_hit;
    logic                        in_window;
    logic [`FETCH_WB_ADDR_W-1:0] win_off;
    fetch_pkg::ctrl_reg_e        reg_idx;
    logic [`FETCH_XLEN-1:0]      fetch_count;
    logic [`FETCH_XLEN-1:0]      rd_val;
    logic [`FETCH_XLEN-1:0]      ctrl_new;
    logic [`FETCH_XLEN-1:0]      rv_new;
    logic [`FETCH_XLEN-1:0]      lat_new;

    function automatic logic [31:0] apply_sel(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  sel
    );
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign access    = wb_cyc && wb_stb && !wb_ack;    // One ack per strobe
    assign wr_access = access && wb_we;
    assign reg_hit   = wb_adr[`FETCH_WB_ADDR_W-1:4] == '0;
    assign in_window = wb_adr >= `FETCH_MEM_WINDOW;
    assign win_off   = wb_adr - `FETCH_MEM_WINDOW;
    assign reg_idx   = fetch_pkg::ctrl_reg_e'(wb_adr[3:2]);

    assign ctrl_new = apply_sel({31'd0, enable}, wb_dat_w, wb_sel);
    assign rv_new   = apply_sel(reset_vector, wb_dat_w, wb_sel);
    assign lat_new  = apply_sel({29'd0, latency}, wb_dat_w, wb_sel);

    // Window writes go straight to the RAM
    assign mem_wr_en   = wr_access && in_window;
    assign mem_wr_addr = win_off[9:2];
    assign mem_wr_data = wb_dat_w;

    always_comb begin
        rd_val = '0;                                   // Window and holes read zero
        if (reg_hit) begin
            case (reg_idx)
                fetch_pkg::reg_ctrl:         rd_val = {31'd0, enable};
                fetch_pkg::reg_reset_vector: rd_val = reset_vector;
                fetch_pkg::reg_latency:      rd_val = {29'd0, latency};
                fetch_pkg::reg_fetch_count:  rd_val = fetch_count;
                default:                     rd_val = '0;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack       <= 1'b0;
            enable       <= 1'b0;
            reset_vector <= '0;
            latency      <= 3'd1;
            fetch_count  <= '0;
        end else begin
            wb_ack <= access;
            if (wr_access && reg_hit) begin
                case (reg_idx)
                    fetch_pkg::reg_ctrl:         enable       <= ctrl_new[0];
                    fetch_pkg::reg_reset_vector: reset_vector <= rv_new;
                    fetch_pkg::reg_latency:      latency      <= lat_new[2:0];
                    default: ;
                endcase
            end
            if (wr_access && reg_hit && reg_idx == fetch_pkg::reg_fetch_count) begin
                fetch_count <= '0;                     // Any value clears
            end else if (delivered) begin
                fetch_count <= fetch_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_val;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`FETCH_WB_ADDR_W-1:0] wb_adr,
    input  logic [`FETCH_XLEN-1:0]      wb_dat_w,
    input  logic [3:0]                  wb_sel,
    output logic [`FETCH_XLEN-1:0]      wb_dat_r,
    output logic                        wb_ack,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [`FETCH_XLEN-1:0]      redirect_pc,
    output logic                        id_valid,
    output logic [`FETCH_XLEN-1:0]      id_pc,
    output logic [`FETCH_XLEN-1:0]      id_inst
);

    logic                   enable;
    logic [`FETCH_XLEN-1:0] reset_vector;
    logic [2:0]             latency;
    logic                   mem_wr_en;
    logic [7:0]             mem_wr_addr;
    logic [`FETCH_XLEN-1:0] mem_wr_data;
    logic                   delivered;

    imem_if imem ();

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .delivered    (delivered),
        .enable       (enable),
        .reset_vector (reset_vector),
        .latency      (latency),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data)
    );

    fetch_stage u_fetch (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .reset_vector (reset_vector),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .stall        (stall),
        .mem          (imem.fetch),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_inst      (id_inst),
        .delivered    (delivered)
    );

    inst_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .latency (latency),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .mem     (imem.memory)
    );

endmodule

`default_nettype wire

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_tb;

    localparam logic [11:0] ADR_CTRL  = 12'h000;
    localparam logic [11:0] ADR_RVEC  = 12'h004;
    localparam logic [11:0] ADR_LAT   = 12'h008;
    localparam logic [11:0] ADR_COUNT = 12'h00c;
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013;   // addi x0, x0, 0
    localparam int          NUM_ROWS  = 7;

    typedef struct packed {
        int          lat;
        logic [31:0] rvec;
        int          stall_level;    // Stall odds out of 16
        int          redir_at;       // Words before redirect, 0 for none
        logic [31:0] redir_pc;
        int          n_words;
    } row_t;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [11:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        id_valid;
    logic [31:0] id_pc;
    logic [31:0] id_inst;

    row_t               rows [NUM_ROWS];
    logic [31:0]        mirror [0:`FETCH_MEM_WORDS-1];
    fetch_pkg::opcode_e op_table [5];
    logic [31:0]        rng;
    int                 errors;
    int                 tests;
    int                 failed_tests;

    fetch_top uut (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .id_valid    (id_valid),
        .id_pc       (id_pc),
        .id_inst     (id_inst)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone host
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wb_access(input logic we, input logic [11:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        @(negedge clk);
        while (!wb_ack && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            $display("Timeout at %0t: no ack for access to %h", $time, adr);
            errors++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;                               // Released on the ack cycle
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, 4'hf, data);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: FAILED", tests, name);
            failed_tests++;
        end
    endtask

    // Let trailing responses drain once fetch is disabled
    task automatic drain_pipeline();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 12 && waited < 300) begin
            @(negedge clk);
            stall = 1'b0;
            waited++;
            quiet = id_valid ? 0 : quiet + 1;
        end
        if (quiet < 12) begin
            $display("Timeout at %0t: fetch stage did not go quiet after disable", $time);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode model for one table row
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_row(input row_t r);
        logic [31:0] exp_pc;
        logic [31:0] data;
        logic [31:0] prev_pc;
        logic [31:0] prev_inst;
        logic        prev_valid;
        logic        prev_stall;
        logic        prev_redirect;
        logic        redir_done;
        logic        first_seen;
        int          got;
        int          n;
        wb_write(ADR_LAT, 32'(r.lat), 4'hf);
        wb_write(ADR_RVEC, r.rvec, 4'hf);
        wb_write(ADR_CTRL, 32'd1, 4'hf);             // Cycle count starts at the ack
        exp_pc        = r.rvec;
        prev_pc       = '0;
        prev_inst     = '0;
        prev_valid    = 1'b0;
        prev_stall    = 1'b0;
        prev_redirect = 1'b0;
        redir_done    = 1'b0;
        first_seen    = 1'b0;
        got           = 0;
        n             = 0;
        while (got < r.n_words && n < 1000) begin
            @(negedge clk);
            n++;
            if (prev_redirect && id_valid) begin
                $display("Error at %0t: id_valid high in the cycle after a redirect", $time);
                errors++;
            end
            if (prev_valid && prev_stall && !prev_redirect) begin
                if (id_valid !== 1'b1) report_mismatch("id_valid under stall", id_valid, 1);
                if (id_pc !== prev_pc) report_mismatch("id_pc under stall", id_pc, prev_pc);
                if (id_inst !== prev_inst) report_mismatch("id_inst under stall", id_inst,
                                                           prev_inst);
            end
            if (!id_valid && id_inst !== NOP_WORD) begin
                report_mismatch("id_inst while idle", id_inst, NOP_WORD);
            end
            rng   = xorshift(rng);
            stall = first_seen && (int'(rng[3:0]) < r.stall_level);
            if (id_valid && !stall) begin
                if (!first_seen && n != r.lat + 2) begin
                    report_mismatch("first id_valid cycle", n, r.lat + 2);
                end
                first_seen = 1'b1;
                if (id_pc !== exp_pc) report_mismatch("id_pc", id_pc, exp_pc);
                if (id_inst !== mirror[exp_pc[9:2]]) report_mismatch("id_inst", id_inst,
                                                                     mirror[exp_pc[9:2]]);
                exp_pc = exp_pc + 32'd4;
                got++;
            end
            redirect = 1'b0;
            if (r.redir_at != 0 && !redir_done && got == r.redir_at) begin
                redirect    = 1'b1;
                redirect_pc = r.redir_pc;
                exp_pc      = r.redir_pc;            // Old stream ends here
                redir_done  = 1'b1;
            end
            prev_valid    = id_valid;
            prev_stall    = stall;
            prev_redirect = redirect;
            prev_pc       = id_pc;
            prev_inst     = id_inst;
        end
        if (got < r.n_words) begin
            $display("Timeout at %0t: collected %0d of %0d words", $time, got, r.n_words);
            errors++;
        end
        @(negedge clk);
        stall    = 1'b1;                             // Freeze hand-over for the count
        redirect = 1'b0;
        wb_write(ADR_CTRL, 32'd0, 4'hf);
        wb_read(ADR_COUNT, data);
        if (data !== 32'(got)) report_mismatch("fetch_count", data, got);
        drain_pipeline();
        wb_write(ADR_COUNT, 32'h5a5a_0001, 4'hf);
        wb_read(ADR_COUNT, data);
        if (data !== 32'd0) report_mismatch("fetch_count after clear", data, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int          errs;
        logic [31:0] data;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = '0;
        stall        = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        rng          = 32'h9857_5baf;
        op_table = '{fetch_pkg::op_imm, fetch_pkg::op_lui, fetch_pkg::op_jal,
                     fetch_pkg::op_branch, fetch_pkg::op_load};
        //         lat  rvec         stall redir redir_pc     words
        rows[0] = '{1, 32'h0000_0000, 0,    0,   32'h0000_0000, 20};
        rows[1] = '{2, 32'h0000_0040, 0,    6,   32'h0000_0200, 16};
        rows[2] = '{3, 32'h0000_0100, 6,    0,   32'h0000_0000, 20};
        rows[3] = '{4, 32'h0000_0010, 8,    5,   32'h0000_0080, 16};
        rows[4] = '{5, 32'h0000_03c0, 4,    8,   32'h0000_0020, 16};
        rows[5] = '{6, 32'h0000_0204, 10,   3,   32'h0000_0300, 12};
        rows[6] = '{7, 32'h0000_00a8, 3,    0,   32'h0000_0000, 12};
        repeat (4) @(negedge clk);
        rst = 1'b0;

        errs = errors;
        wb_read(ADR_CTRL, data);
        if (data !== 32'd0) report_mismatch("ctrl after reset", data, 0);
        wb_read(ADR_COUNT, data);
        if (data !== 32'd0) report_mismatch("fetch_count after reset", data, 0);
        wb_read(ADR_LAT, data);
        if (data !== 32'd1) report_mismatch("latency after reset", data, 1);
        wb_write(ADR_RVEC, 32'h1234_5678, 4'hf);
        wb_write(ADR_RVEC, 32'haaaa_bbbb, 4'b0101);  // Bytes 0 and 2 only
        wb_read(ADR_RVEC, data);
        if (data !== 32'h12aa_56bb) report_mismatch("reset_vector", data, 32'h12aa_56bb);
        wb_write(ADR_LAT, 32'h0000_0005, 4'b0001);
        wb_write(ADR_LAT, 32'h0000_0007, 4'b1110);   // Misses byte 0
        wb_read(ADR_LAT, data);
        if (data !== 32'd5) report_mismatch("latency", data, 5);
        finish_test("register access", errs);

        errs = errors;
        for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
            rng       = xorshift(rng);
            mirror[i] = {rng[31:7], op_table[i % 5]};
            wb_write(`FETCH_MEM_WINDOW + 12'(4 * i), mirror[i], 4'hf);
        end
        wb_read(`FETCH_MEM_WINDOW + 12'h010, data);
        if (data !== 32'd0) report_mismatch("window read", data, 0);
        finish_test("memory load", errs);

        for (int k = 0; k < NUM_ROWS; k++) begin
            errs = errors;
            run_row(rows[k]);
            finish_test($sformatf("fetch row %0d latency %0d", k, rows[k].lat), errs);
        end

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/imem_if.sv
verilog/fetch_stage.sv
verilog/inst_mem.sv
verilog/fetch_ctrl.sv
verilog/fetch_top.sv
verif/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
